// ==== cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

  // Width of a register and of the whole data path
  localparam int data_w = 16;
  // Sixteen architectural registers, R0 reads as zero
  localparam int reg_addr_w = 4;

  // Opcodes kept in this core
  // Codes 1000, 1001 and 1100 to 1110 are not named and fall into the add path
  typedef enum logic [3:0] {
    op_add  = 4'b0000,
    op_addz = 4'b0001,
    op_sub  = 4'b0010,
    op_and  = 4'b0011,
    op_nor  = 4'b0100,
    op_sll  = 4'b0101,
    op_srl  = 4'b0110,
    op_sra  = 4'b0111,
    op_lhb  = 4'b1010,
    op_llb  = 4'b1011,
    op_hlt  = 4'b1111
  } opcode_e;

  // ALU function codes, equal to the low opcode bits for the ALU class
  typedef enum logic [2:0] {
    func_add = 3'b000,
    func_lhb = 3'b001,
    func_sub = 3'b010,
    func_and = 3'b011,
    func_nor = 3'b100,
    func_sll = 3'b101,
    func_srl = 3'b110,
    func_sra = 3'b111
  } alu_func_e;

  // One instruction word seen as register form or as immediate form
  typedef union packed {
    struct packed {
      opcode_e               opcode;
      logic [reg_addr_w-1:0] rd;
      logic [reg_addr_w-1:0] rs;
      logic [reg_addr_w-1:0] rt;
    } reg_form;
    struct packed {
      opcode_e               opcode;
      logic [reg_addr_w-1:0] rd;
      logic [7:0]            imm8;
    } imm_form;
  } instr_u;

  // Report of one executed instruction
  typedef struct packed {
    logic                  valid;
    logic [reg_addr_w-1:0] dst;
    logic [data_w-1:0]     data;
    logic                  zr;
  } retire_t;

  // Decoder outputs consumed by the ALU and the retire stage
  typedef struct packed {
    logic                  alu_op;
    logic                  src1_sel;
    alu_func_e             func;
    logic [3:0]            shamt;
    logic [7:0]            imm8;
    logic [reg_addr_w-1:0] dst;
    logic                  we;
    logic                  hlt;
  } dec_ctrl_t;

endpackage

`default_nettype wire

// ==== instr_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module instr_decode import cpu_pkg::*; (
  input  instr_u                instr,
  input  logic                  zr,
  output logic [reg_addr_w-1:0] p0_addr,
  output logic [reg_addr_w-1:0] p1_addr,
  output dec_ctrl_t             ctrl
);

  opcode_e opcode;
  logic    is_shift;
  logic    is_alu;

  // Opcode sits in the same place in both instruction forms
  assign opcode = instr.reg_form.opcode;

  // Everything with a clear top opcode bit is a plain ALU operation
  assign is_alu = ~opcode[3];

  assign is_shift = (opcode == op_sll) || (opcode == op_srl) || (opcode == op_sra);

  // LHB merges into rd, so rd has to be read on port 0
  assign p0_addr = (opcode == op_lhb) ? instr.imm_form.rd : instr.reg_form.rs;

  // Shifts take their value on port 1, since the ALU shifts operand B
  // The shift amount then comes from the rt field instead
  assign p1_addr = is_shift ? instr.reg_form.rs : instr.reg_form.rt;

  always_comb begin
    ctrl.alu_op   = is_alu;
    ctrl.src1_sel = ~is_alu;
    ctrl.imm8     = instr.imm_form.imm8;
    ctrl.hlt      = &opcode;
    ctrl.we       = ~ctrl.hlt;

    // ALU shifts use rt as the amount, LLB always shifts by eight
    if (is_alu) begin
      ctrl.shamt = instr.reg_form.rt;
    end else begin
      ctrl.shamt = 4'd8;
    end

    // ADDZ without a set zero flag is redirected to R0, which drops the write
    if ((opcode == op_addz) && !zr) begin
      ctrl.dst = '0;
    end else begin
      ctrl.dst = instr.reg_form.rd;
    end

    // ALU class passes the low opcode bits through, except ADDZ which is an add
    if (is_alu) begin
      if (opcode == op_addz) begin
        ctrl.func = func_add;
      end else begin
        ctrl.func = alu_func_e'(opcode[2:0]);
      end
    end else begin
      case (opcode)
        op_lhb: begin
          ctrl.func = func_lhb;
        end
        // LLB is an arithmetic right shift of the immediate placed in the high byte
        op_llb: begin
          ctrl.func = func_sra;
        end
        // Remaining high opcodes take the LW/SW route, which is an add
        default: begin
          ctrl.func = func_add;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== reg_file.sv ====
`timescale 1ns/1ns
`default_nettype none

module reg_file import cpu_pkg::*; #(
  parameter int data_w     = cpu_pkg::data_w,
  parameter int reg_addr_w = cpu_pkg::reg_addr_w
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [reg_addr_w-1:0] p0_addr,
  input  logic [reg_addr_w-1:0] p1_addr,
  output logic [data_w-1:0]     src0,
  output logic [data_w-1:0]     src1,
  input  logic                  wr_en,
  input  logic [reg_addr_w-1:0] wr_addr,
  input  logic [data_w-1:0]     wr_data
);

  localparam int num_regs = 2 ** reg_addr_w;

  logic [data_w-1:0] regs [num_regs];

  // All registers come out of reset as zero
  // A write to R0 is silently dropped
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && (wr_addr != '0)) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // Reads are combinational
  // The write lands at the accepting edge, so the next instruction sees it
  always_comb begin
    if (p0_addr == '0) begin
      src0 = '0;
    end else begin
      src0 = regs[p0_addr];
    end
  end

  always_comb begin
    if (p1_addr == '0) begin
      src1 = '0;
    end else begin
      src1 = regs[p1_addr];
    end
  end

endmodule

`default_nettype wire

// ==== alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu import cpu_pkg::*; #(
  parameter int data_w = cpu_pkg::data_w
) (
  input  logic [data_w-1:0] src0,
  input  logic [data_w-1:0] src1,
  input  dec_ctrl_t         ctrl,
  output logic [data_w-1:0] result,
  output logic              res_zero
);

  logic [data_w-1:0] opnd_b;
  logic [data_w-1:0] imm_high;

  // Immediate sits in the top byte with zeros below it
  assign imm_high = {ctrl.imm8, {(data_w - 8){1'b0}}};

  // Immediate forms replace the second register operand
  assign opnd_b = ctrl.src1_sel ? imm_high : src1;

  always_comb begin
    case (ctrl.func)
      func_add: begin
        result = src0 + opnd_b;
      end
      // New high byte over the low byte of rd, which arrives on src0
      func_lhb: begin
        result = {ctrl.imm8, src0[data_w-9:0]};
      end
      func_sub: begin
        result = src0 - opnd_b;
      end
      func_and: begin
        result = src0 & opnd_b;
      end
      func_nor: begin
        result = ~(src0 | opnd_b);
      end
      // Shifts work on operand B, which is what lets LLB reuse SRA
      func_sll: begin
        result = opnd_b << ctrl.shamt;
      end
      func_srl: begin
        result = opnd_b >> ctrl.shamt;
      end
      // Shifting the high-byte immediate down by eight sign-extends imm8
      func_sra: begin
        result = $signed(opnd_b) >>> ctrl.shamt;
      end
      default: begin
        result = src0 + opnd_b;
      end
    endcase
  end

  // Zero indication for the flag in the retire stage
  assign res_zero = (result == '0);

endmodule

`default_nettype wire

// ==== retire_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module retire_stage import cpu_pkg::*; #(
  parameter int data_w     = cpu_pkg::data_w,
  parameter int reg_addr_w = cpu_pkg::reg_addr_w
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  instr_valid,
  input  dec_ctrl_t             ctrl,
  input  logic [data_w-1:0]     result,
  input  logic                  res_zero,
  output logic                  zr,
  output logic                  halted,
  output logic                  wr_en,
  output logic [reg_addr_w-1:0] wr_addr,
  output logic [data_w-1:0]     wr_data,
  output retire_t               retire
);

  logic accept;
  logic zr_next;

  // HLT is the only instruction with we low, so it is consumed here and never retires
  assign accept = instr_valid && !halted && ctrl.we;

  // Only the ALU class moves the zero flag and loads leave it alone
  assign zr_next = ctrl.alu_op ? res_zero : zr;

  // Register write happens at the same edge that accepts the instruction
  assign wr_en   = accept;
  assign wr_addr = ctrl.dst;
  assign wr_data = result;

  always_ff @(posedge clk) begin
    if (rst) begin
      zr <= 1'b0;
    end else if (accept) begin
      zr <= zr_next;
    end
  end

  // Once set, halted holds until the next reset
  always_ff @(posedge clk) begin
    if (rst) begin
      halted <= 1'b0;
    end else if (instr_valid && ctrl.hlt) begin
      halted <= 1'b1;
    end
  end

  // Report carries the flag value as it stands after this instruction
  always_ff @(posedge clk) begin
    if (rst) begin
      retire.valid <= 1'b0;
    end else begin
      retire.valid <= accept;
      if (accept) begin
        retire.dst  <= ctrl.dst;
        retire.data <= result;
        retire.zr   <= zr_next;
      end
    end
  end

endmodule

`default_nettype wire

// ==== cpu_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_core import cpu_pkg::*; #(
  parameter int data_w     = cpu_pkg::data_w,
  parameter int reg_addr_w = cpu_pkg::reg_addr_w
) (
  input  logic    clk,
  input  logic    rst,
  input  instr_u  instr,
  input  logic    instr_valid,
  output retire_t retire,
  output logic    halted
);

  // Decode to register file and ALU
  logic [reg_addr_w-1:0] p0_addr;
  logic [reg_addr_w-1:0] p1_addr;
  dec_ctrl_t             ctrl;

  // Operands and ALU outputs
  logic [data_w-1:0]     src0;
  logic [data_w-1:0]     src1;
  logic [data_w-1:0]     result;
  logic                  res_zero;

  // Zero flag fed back to the decoder for ADDZ
  logic                  zr;

  // Write port driven by the retire stage
  logic                  wr_en;
  logic [reg_addr_w-1:0] wr_addr;
  logic [data_w-1:0]     wr_data;

  instr_decode u_decode (
    .instr   (instr),
    .zr      (zr),
    .p0_addr (p0_addr),
    .p1_addr (p1_addr),
    .ctrl    (ctrl)
  );

  reg_file #(
    .data_w     (data_w),
    .reg_addr_w (reg_addr_w)
  ) u_reg_file (
    .clk     (clk),
    .rst     (rst),
    .p0_addr (p0_addr),
    .p1_addr (p1_addr),
    .src0    (src0),
    .src1    (src1),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data)
  );

  alu #(
    .data_w (data_w)
  ) u_alu (
    .src0     (src0),
    .src1     (src1),
    .ctrl     (ctrl),
    .result   (result),
    .res_zero (res_zero)
  );

  retire_stage #(
    .data_w     (data_w),
    .reg_addr_w (reg_addr_w)
  ) u_retire (
    .clk         (clk),
    .rst         (rst),
    .instr_valid (instr_valid),
    .ctrl        (ctrl),
    .result      (result),
    .res_zero    (res_zero),
    .zr          (zr),
    .halted      (halted),
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .retire      (retire)
  );

endmodule

`default_nettype wire

// ==== tb_cpu_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_cpu_core import cpu_pkg::*; ;

  // Each trace line holds six words: test, instr, dst, data, zr, halted
  localparam int fields      = 6;
  localparam int max_entries = 64;

  logic    clk;
  logic    rst;
  instr_u  instr;
  logic    instr_valid;
  retire_t retire;
  logic    halted;

  logic [15:0] trace_mem [fields * max_entries];

  logic [31:0] lfsr;
  int          num_entries;
  int          cycle_cnt;
  int          cycle_limit;
  int          total_errs;
  int          total_checks;
  int          num_tests;
  int          test_errs;
  int          test_checks;
  logic [15:0] cur_test;

  cpu_core #(
    .data_w     (data_w),
    .reg_addr_w (reg_addr_w)
  ) dut0 (
    .clk         (clk),
    .rst         (rst),
    .instr       (instr),
    .instr_valid (instr_valid),
    .retire      (retire),
    .halted      (halted)
  );

  always #10 clk = ~clk;

  // Run limit grows with the trace, since each entry takes at most four cycles
  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("Run timed out after %0d cycles", cycle_cnt);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  // One Galois step with the x^32 + x^22 + x^2 + x + 1 polynomial
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h8020_0003;
    end
    return n;
  endfunction

  // Two random bits give between zero and three idle cycles
  task automatic take_gap(output int gap);
    gap = 0;
    for (int b = 0; b < 2; b++) begin
      gap = gap * 2 + lfsr[0];
      lfsr = lfsr_step(lfsr);
    end
  endtask

  task automatic report_value(input string name, input logic [15:0] exp_v,
                              input logic [15:0] act_v);
    $display("[ERROR] t=%0t %s expected %h got %h", $time, name, exp_v, act_v);
    total_errs  = total_errs + 1;
    test_errs   = test_errs + 1;
  endtask

  task automatic finish_test();
    $display("Test %0d done: %0d checks, %0d errors", cur_test, test_checks, test_errs);
    num_tests   = num_tests + 1;
    test_checks = 0;
    test_errs   = 0;
  endtask

  // Compare the retire report of trace entry idx, accepted at the last rising edge
  task automatic check_entry(input int idx);
    logic [15:0] test_no;
    logic [15:0] exp_dst;
    logic [15:0] exp_data;
    logic [15:0] exp_zr;
    logic [15:0] exp_halt;
    test_no  = trace_mem[idx * fields];
    exp_dst  = trace_mem[idx * fields + 2];
    exp_data = trace_mem[idx * fields + 3];
    exp_zr   = trace_mem[idx * fields + 4];
    exp_halt = trace_mem[idx * fields + 5];
    if (test_no != cur_test) begin
      if (cur_test != 16'h0000) begin
        finish_test();
      end
      cur_test = test_no;
    end
    test_checks  = test_checks + 1;
    total_checks = total_checks + 1;
    // A halted core retires nothing, HLT itself included
    if (exp_halt[0]) begin
      if (retire.valid !== 1'b0) begin
        report_value("retire.valid", 16'h0, {15'h0, retire.valid});
      end
    end else begin
      if (retire.valid !== 1'b1) begin
        report_value("retire.valid", 16'h1, {15'h0, retire.valid});
      end
      if (retire.dst !== exp_dst[3:0]) begin
        report_value("retire.dst", exp_dst, {12'h0, retire.dst});
      end
      if (retire.data !== exp_data) begin
        report_value("retire.data", exp_data, retire.data);
      end
      if (retire.zr !== exp_zr[0]) begin
        report_value("retire.zr", exp_zr, {15'h0, retire.zr});
      end
    end
    if (halted !== exp_halt[0]) begin
      report_value("halted", exp_halt, {15'h0, halted});
    end
  endtask

  initial begin
    int idx;
    int prev;
    int cur;
    int gap_left;
    clk          = 1'b0;
    rst          = 1'b1;
    instr        = '0;
    instr_valid  = 1'b0;
    lfsr         = 32'h24486c27;
    cycle_cnt    = 0;
    total_errs   = 0;
    total_checks = 0;
    num_tests    = 0;
    test_errs    = 0;
    test_checks  = 0;
    cur_test     = 16'h0000;

    $readmemh("cpu_trace.txt", trace_mem);
    // The trace ends at a line whose test number is ff
    num_entries = 0;
    while (num_entries < max_entries && trace_mem[num_entries * fields] !== 16'h00ff &&
           !$isunknown(trace_mem[num_entries * fields])) begin
      num_entries = num_entries + 1;
    end
    cycle_limit = num_entries * 5 + 50;
    if (num_entries == 0) begin
      $display("The trace file held no entries");
      total_errs = total_errs + 1;
    end

    repeat (8) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    total_checks = total_checks + 1;
    if (retire.valid !== 1'b0 || halted !== 1'b0) begin
      $display("[ERROR] t=%0t reset state expected valid 0 halted 0 got %b %b",
               $time, retire.valid, halted);
      total_errs = total_errs + 1;
    end

    // Each loop pass is one cycle, driving a new slot and checking the previous one
    idx  = 0;
    prev = -1;
    take_gap(gap_left);
    while (idx < num_entries || prev >= 0) begin
      @(posedge clk);
      if (idx < num_entries && gap_left == 0) begin
        instr       <= trace_mem[idx * fields + 1];
        instr_valid <= 1'b1;
        cur = idx;
        idx = idx + 1;
        take_gap(gap_left);
      end else begin
        instr_valid <= 1'b0;
        if (gap_left > 0) begin
          gap_left = gap_left - 1;
        end
        cur = -1;
      end
      @(negedge clk);
      if (prev >= 0) begin
        check_entry(prev);
      end else if (retire.valid !== 1'b0) begin
        // An idle slot must not produce a report
        report_value("retire.valid", 16'h0, {15'h0, retire.valid});
      end
      prev = cur;
    end

    if (cur_test != 16'h0000) begin
      finish_test();
    end
    $display("Summary: %0d tests, %0d checks, %0d errors", num_tests, total_checks,
             total_errs);
    if (total_errs == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== cpu_trace.txt ====
// Columns: test, instr, expected dst, expected data, expected zr, expected halted
// A test number of ff ends the trace
// Test 1 loads with LLB and LHB
01 b105 1 0005 0 0
01 b283 2 ff83 0 0
01 a212 2 1283 0 0
01 b30f 3 000f 0 0
01 a4a5 4 a500 0 0
01 b57f 5 007f 0 0
// Test 2 register ALU operations
02 0613 6 0014 0 0
02 2711 7 0000 1 0
02 2813 8 fff6 0 0
02 3925 9 0003 0 0
02 4a13 a fff0 0 0
02 5b54 b 07f0 0 0
02 6c48 c 00a5 0 0
02 7d44 d fa50 0 0
02 3e14 e 0000 1 0
// Test 3 ADDZ with the zero flag set and clear
03 1611 6 000a 0 0
03 1633 0 001e 0 0
03 0960 9 000a 0 0
03 1a00 0 0000 1 0
03 1a13 a 0014 0 0
// Test 4 writes to R0 are dropped
04 b055 0 0055 0 0
04 0013 0 0014 0 0
04 0b01 b 0005 0 0
04 2c00 c 0000 1 0
// Test 5 dependent chain
05 b1ff 1 ffff 1 0
05 0211 2 fffe 0 0
05 732f 3 ffff 0 0
05 2431 4 0000 1 0
05 1523 5 fffd 0 0
// Test 6 HLT stops all later reports
06 f000 0 0000 0 1
06 0611 0 0000 0 1
06 b701 0 0000 0 1
ff 0000 0 0000 0 0

// ==== tb.f ====
cpu_pkg.sv
instr_decode.sv
reg_file.sv
alu.sv
retire_stage.sv
cpu_core.sv
tb_cpu_core.sv
